// ==== rtl/bw_pkg.sv ====
/* Shared types and constants for the cabinet input subsystem.
   JOYCFG keeps only 4 bits, and game bytes above 3 decode to NONE. */

package bw_pkg;

	// ====================
	// Bus and register map
	// ====================

	localparam int WB_ADR_W  = 4;
	localparam int WB_DAT_W  = 8;
	localparam int DIP_BANKS = 8;
	localparam int DIP_IDX_W = $clog2(DIP_BANKS);

	localparam logic [WB_ADR_W-1:0] ADR_GAME     = 4'd0;
	localparam logic [WB_ADR_W-1:0] ADR_JOYCFG   = 4'd1;
	// DIP byte n lives at ADR_DIP_BASE + n
	localparam logic [WB_ADR_W-1:0] ADR_DIP_BASE = 4'd8;

	// ====================
	// Controller and port widths
	// ====================

	// Raw word from USB or from a retro adapter
	localparam int JOY_W    = 16;
	// Used low part of a player word in USB layout
	localparam int PLAYER_W = 12;
	localparam int PORT_W   = 8;
	// Cabinet inputs are active low
	localparam logic [PORT_W-1:0] PORT_IDLE = '1;

	// ====================
	// Enums
	// ====================

	typedef enum logic [2:0] {
		BWIDOW   = 3'd0,
		GRAVITAR = 3'd1,
		LUNARBAT = 3'd2,
		SPACDUEL = 3'd3,
		NONE     = 3'd4
	} game_e;

	// Both codes 2 and 3 select the mega-drive adapter
	typedef enum logic [1:0] {
		OFF       = 2'd0,
		DB15      = 2'd1,
		DB9MD     = 2'd2,
		DB9MD_ALT = 2'd3
	} joy_src_e;

	// ====================
	// Structs
	// ====================

	// Layout matches JOYCFG bits 3..0
	typedef struct packed {
		logic     pause_on_osd;
		logic     two_player;
		joy_src_e src;
	} joy_cfg_t;

	typedef struct packed {
		logic coin;
		logic start1;
		logic start2;
		logic pause;
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire_up;
		logic fire_down;
		logic fire_left;
		logic fire_right;
	} ctrl_t;

	typedef struct packed {
		logic [JOY_W-1:0] p1;
		logic [JOY_W-1:0] p2;
	} db_pair_t;

	typedef struct packed {
		logic [PORT_W-1:0] in0;
		logic [PORT_W-1:0] in1;
		logic [PORT_W-1:0] in2;
		logic [PORT_W-1:0] in3;
		logic [PORT_W-1:0] in4;
	} ports_t;

endpackage

// ==== rtl/cfg_regs.sv ====
/* Wishbone classic slave with one-cycle ack and no wait states.
   The master must drop stb after ack before the next request. */
`timescale 1ns/1ps

module cfg_regs (
	input  logic                         clk_12,
	input  logic                         rst_n,
	input  logic                         wb_cyc,
	input  logic                         wb_stb,
	input  logic                         wb_we,
	input  logic [bw_pkg::WB_ADR_W-1:0]  wb_adr,
	input  logic [bw_pkg::WB_DAT_W-1:0]  wb_dat_w,
	output logic [bw_pkg::WB_DAT_W-1:0]  wb_dat_r,
	output logic                         wb_ack,
	output bw_pkg::game_e                game,
	output bw_pkg::joy_cfg_t             jcfg,
	output logic [bw_pkg::WB_DAT_W-1:0]  dip0,
	output logic [bw_pkg::WB_DAT_W-1:0]  dip1,
	output logic [bw_pkg::WB_DAT_W-1:0]  dip2
);

	// Raw game byte, kept whole so it reads back as written
	logic [bw_pkg::WB_DAT_W-1:0] game_q;
	bw_pkg::joy_cfg_t            jcfg_q;
	logic [bw_pkg::DIP_BANKS-1:0][bw_pkg::WB_DAT_W-1:0] dip_q;

	logic                         req;
	logic                         is_dip;
	logic [bw_pkg::DIP_IDX_W-1:0] dip_idx;
	logic [bw_pkg::WB_DAT_W-1:0]  rd_data;

	// New request only while ack is low, so ack lasts one cycle
	assign req     = wb_cyc & wb_stb & ~wb_ack;
	// The whole upper half of the address space is DIP bytes
	assign is_dip  = wb_adr >= bw_pkg::ADR_DIP_BASE;
	assign dip_idx = bw_pkg::DIP_IDX_W'(wb_adr - bw_pkg::ADR_DIP_BASE);

	// ====================
	// Read mux
	// ====================

	always_comb begin
		rd_data = '0;
		if (wb_adr == bw_pkg::ADR_GAME) begin
			rd_data = game_q;
		end else if (wb_adr == bw_pkg::ADR_JOYCFG) begin
			// Upper JOYCFG bits read zero
			rd_data[3:0] = jcfg_q;
		end else if (is_dip) begin
			rd_data = dip_q[dip_idx];
		end
	end

	// ====================
	// Bus cycle and writes
	// ====================

	always_ff @(posedge clk_12) begin
		if (!rst_n) begin
			wb_ack <= 1'b0;
			game_q <= '0;
			jcfg_q <= '0;
			dip_q  <= '0;
		end else begin
			wb_ack <= req;
			if (req && wb_we) begin
				if (wb_adr == bw_pkg::ADR_GAME) begin
					game_q <= wb_dat_w;
				end else if (wb_adr == bw_pkg::ADR_JOYCFG) begin
					jcfg_q <= bw_pkg::joy_cfg_t'(wb_dat_w[3:0]);
				end else if (is_dip) begin
					dip_q[dip_idx] <= wb_dat_w;
				end
				// Addresses 2 to 7 drop the write
			end
		end
	end

	// Read data valid together with ack
	always_ff @(posedge clk_12) begin
		if (req) begin
			wb_dat_r <= rd_data;
		end
	end

	// Game decode, combinational so a write reaches the port mux at once
	always_comb begin
		case (game_q)
			8'd0:    game = bw_pkg::BWIDOW;
			8'd1:    game = bw_pkg::GRAVITAR;
			8'd2:    game = bw_pkg::LUNARBAT;
			8'd3:    game = bw_pkg::SPACDUEL;
			default: game = bw_pkg::NONE;
		endcase
	end

	assign jcfg = jcfg_q;
	// Only the first three DIP bytes feed the cabinet
	assign dip0 = dip_q[0];
	assign dip1 = dip_q[1];
	assign dip2 = dip_q[2];

	// Ack follows a request seen on the previous edge
	ack_needs_req: assert property (@(posedge clk_12) disable iff (!rst_n)
		wb_ack |-> $past(wb_cyc && wb_stb));

	// Ack never stretches over two cycles
	ack_single: assert property (@(posedge clk_12) disable iff (!rst_n)
		wb_ack |=> !wb_ack);

endmodule

// ==== rtl/joy_merge.sv ====
/* Combinational player merge. The retro player 2 needs both a source
   and two_player, else player 2 comes from USB. */
`timescale 1ns/1ps

module joy_merge (
	input  logic [bw_pkg::JOY_W-1:0] usb_p1,
	input  logic [bw_pkg::JOY_W-1:0] usb_p2,
	input  bw_pkg::db_pair_t         db9,
	input  bw_pkg::db_pair_t         db15,
	input  bw_pkg::joy_cfg_t         jcfg,
	output bw_pkg::ctrl_t            ctrl
);

	// Player words use the USB layout
	// 3..0 R L D U, 7..4 fire R L D U, 8 start1, 9 start2, 10 coin, 11 pause
	logic [bw_pkg::PLAYER_W-1:0] p1;
	logic [bw_pkg::PLAYER_W-1:0] p2;
	bw_pkg::db_pair_t            retro;
	logic                        retro_on;
	logic                        retro_p2;

	// Adapter word into USB layout
	// Player 2 takes its start buttons the other way round
	function automatic logic [bw_pkg::PLAYER_W-1:0] remap(
		input logic [bw_pkg::JOY_W-1:0] raw,
		input logic                     second
	);
		logic [bw_pkg::PLAYER_W-1:0] w;
		w[3:0] = raw[3:0];
		// Fire right and left trade places on the adapters
		w[4]   = raw[5];
		w[5]   = raw[4];
		w[6]   = raw[6];
		w[7]   = raw[7];
		w[8]   = second ? raw[9] : raw[10];
		w[9]   = second ? raw[10] : raw[9];
		// Start plus fire B also inserts a coin
		w[10]  = raw[11] | (raw[10] & raw[5]);
		w[11]  = raw[8];
		return w;
	endfunction

	// ====================
	// Source selection
	// ====================

	assign retro_on = jcfg.src != bw_pkg::OFF;
	assign retro_p2 = retro_on & jcfg.two_player;
	// src bit 1 picks the mega-drive adapter
	assign retro    = jcfg.src[1] ? db9 : db15;

	always_comb begin
		if (retro_on) begin
			p1 = remap(retro.p1, 1'b0);
		end else begin
			p1 = usb_p1[bw_pkg::PLAYER_W-1:0];
		end

		if (retro_p2) begin
			p2 = remap(retro.p2, 1'b1);
		end else if (retro_on) begin
			// First USB pad moves over to player 2
			p2 = usb_p1[bw_pkg::PLAYER_W-1:0];
		end else begin
			p2 = usb_p2[bw_pkg::PLAYER_W-1:0];
		end
	end

	// ====================
	// Control set
	// ====================

	// Movement from player 1 only
	assign ctrl.up    = p1[3];
	assign ctrl.down  = p1[2];
	assign ctrl.left  = p1[1];
	assign ctrl.right = p1[0];

	// Player 2 stick acts as a second fire stick
	assign ctrl.fire_up    = p1[7] | p2[3];
	assign ctrl.fire_down  = p1[6] | p2[2];
	assign ctrl.fire_left  = p1[5] | p2[1];
	assign ctrl.fire_right = p1[4] | p2[0];

	assign ctrl.start1 = p1[8] | p2[8];
	assign ctrl.start2 = p1[9] | p2[9];
	assign ctrl.coin   = p1[10] | p2[10];
	assign ctrl.pause  = p1[11] | p2[11];

endmodule

// ==== rtl/input_port_mux.sv ====
/* Builds the five active-low cabinet ports, one edge after any input.
   Space Duel and unknown games get the default image. */
`timescale 1ns/1ps

module input_port_mux (
	input  logic                        clk_12,
	input  logic                        rst_n,
	input  bw_pkg::game_e               game,
	input  bw_pkg::ctrl_t               ctrl,
	input  logic [bw_pkg::PORT_W-1:0]   dip0,
	input  logic [bw_pkg::PORT_W-1:0]   dip1,
	input  logic [bw_pkg::PORT_W-1:0]   dip2,
	output bw_pkg::ports_t              ports
);

	bw_pkg::ports_t            nxt;
	logic [bw_pkg::PORT_W-1:0] coin_port;

	// Shared in0 for the three Atari titles
	// Bit 6 held, dip2 bits 0 and 1 swapped into 5..4, coin on bit 1
	assign coin_port = ~{1'b0, 1'b1, dip2[0], dip2[1], 2'b00, ctrl.coin, 1'b0};

	// ====================
	// Port image
	// ====================

	always_comb begin
		// Defaults, DIP bytes on in1 and in2
		nxt.in0 = bw_pkg::PORT_IDLE;
		nxt.in1 = dip0;
		nxt.in2 = dip1;
		nxt.in3 = bw_pkg::PORT_IDLE;
		nxt.in4 = bw_pkg::PORT_IDLE;

		case (game)
			bw_pkg::BWIDOW: begin
				nxt.in0 = coin_port;
				// Move stick
				nxt.in3 = ~{4'b0000, ctrl.up, ctrl.down, ctrl.left, ctrl.right};
				// Fire stick and starts
				nxt.in4 = ~{1'b0, ctrl.start2, ctrl.start1, 1'b0,
					ctrl.fire_up, ctrl.fire_down, ctrl.fire_left, ctrl.fire_right};
			end
			bw_pkg::GRAVITAR: begin
				nxt.in0 = coin_port;
				// Fire left is shield, fire right thrust, fire down fire
				nxt.in3 = ~{3'b000, ctrl.fire_left, ctrl.left, ctrl.right,
					ctrl.fire_right, ctrl.fire_down};
				nxt.in4 = ~{1'b0, ctrl.start2, ctrl.start1, 5'b00000};
			end
			bw_pkg::LUNARBAT: begin
				nxt.in0 = coin_port;
				// No switch banks on this board
				nxt.in1 = bw_pkg::PORT_IDLE;
				nxt.in2 = bw_pkg::PORT_IDLE;
				// Active high on this port
				nxt.in3 = {1'b0, ctrl.start2, ctrl.start1, ctrl.fire_left,
					ctrl.fire_down, ctrl.fire_right, ctrl.right, ctrl.left};
			end
			default: begin
				// Space Duel and NONE keep the defaults
			end
		endcase
	end

	// ====================
	// Output register
	// ====================

	always_ff @(posedge clk_12) begin
		if (!rst_n) begin
			ports.in0 <= bw_pkg::PORT_IDLE;
			ports.in1 <= bw_pkg::PORT_IDLE;
			ports.in2 <= bw_pkg::PORT_IDLE;
			ports.in3 <= bw_pkg::PORT_IDLE;
			ports.in4 <= bw_pkg::PORT_IDLE;
		end else begin
			ports <= nxt;
		end
	end

	// DIP bank 0 lands on in1 one edge later for every game but Lunar Battle
	in1_follows_dip0: assert property (@(posedge clk_12) disable iff (!rst_n)
		($past(rst_n) && $past(game) != bw_pkg::LUNARBAT) |-> ports.in1 == $past(dip0));

endmodule

// ==== rtl/pause_ctrl.sv ====
/* Pause toggles on each button press. pause_request and an open OSD
   hold the CPU only while they last. */
`timescale 1ns/1ps

module pause_ctrl (
	input  logic clk_12,
	input  logic rst_n,
	input  logic pause_btn,
	input  logic pause_request,
	input  logic osd_open,
	input  logic pause_on_osd,
	output logic pause_cpu
);

	logic btn_q;
	logic toggle_q;
	logic toggle_nxt;
	logic osd_hold;

	// Flip on the rising edge of the button
	assign toggle_nxt = toggle_q ^ (pause_btn & ~btn_q);
	// OSD pauses only when enabled in JOYCFG
	assign osd_hold   = osd_open & pause_on_osd;

	// ====================
	// State
	// ====================

	always_ff @(posedge clk_12) begin
		if (!rst_n) begin
			btn_q     <= 1'b0;
			toggle_q  <= 1'b0;
			pause_cpu <= 1'b0;
		end else begin
			btn_q     <= pause_btn;
			toggle_q  <= toggle_nxt;
			// Use the new toggle so a press shows on the same edge
			pause_cpu <= toggle_nxt | pause_request | osd_hold;
		end
	end

endmodule

// ==== rtl/bw_input_top.sv ====
/* Input subsystem top, all logic on clk_12 with a synchronous reset.
   Adapter and USB words are taken as already sampled on clk_12. */
`timescale 1ns/1ps

module bw_input_top (
	input  logic                        clk_12,
	input  logic                        rst_n,
	// Wishbone classic slave
	input  logic                        wb_cyc,
	input  logic                        wb_stb,
	input  logic                        wb_we,
	input  logic [bw_pkg::WB_ADR_W-1:0] wb_adr,
	input  logic [bw_pkg::WB_DAT_W-1:0] wb_dat_w,
	output logic [bw_pkg::WB_DAT_W-1:0] wb_dat_r,
	output logic                        wb_ack,
	// Controllers
	input  logic [bw_pkg::JOY_W-1:0]    usb_p1,
	input  logic [bw_pkg::JOY_W-1:0]    usb_p2,
	input  bw_pkg::db_pair_t            db9,
	input  bw_pkg::db_pair_t            db15,
	input  logic                        pause_request,
	input  logic                        osd_open,
	// Cabinet side
	output bw_pkg::ports_t              ports,
	output logic                        pause_cpu
);

	bw_pkg::game_e               game;
	bw_pkg::joy_cfg_t            jcfg;
	bw_pkg::ctrl_t               ctrl;
	logic [bw_pkg::WB_DAT_W-1:0] dip0;
	logic [bw_pkg::WB_DAT_W-1:0] dip1;
	logic [bw_pkg::WB_DAT_W-1:0] dip2;

	cfg_regs cfg_regs_i (
		.clk_12, .rst_n,
		.wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
		.game, .jcfg, .dip0, .dip1, .dip2
	);

	joy_merge joy_merge_i (
		.usb_p1, .usb_p2, .db9, .db15, .jcfg, .ctrl
	);

	input_port_mux input_port_mux_i (
		.clk_12, .rst_n, .game, .ctrl, .dip0, .dip1, .dip2, .ports
	);

	// Merged pause button drives the toggle
	pause_ctrl pause_ctrl_i (
		.clk_12, .rst_n,
		.pause_btn     (ctrl.pause),
		.pause_request,
		.osd_open,
		.pause_on_osd  (jcfg.pause_on_osd),
		.pause_cpu
	);

endmodule

// ==== tb/bw_ref.svh ====
/* Reference rules for the cabinet inputs, included inside the testbench module.
   The game byte and JOYCFG are taken raw, as they were written over the bus. */
`ifndef BW_REF_SVH
`define BW_REF_SVH

// Adapter word into USB layout, start buttons swapped for player 2
function automatic logic [11:0] ref_player(input logic [15:0] raw, input logic swap);
	logic [11:0] w;
	w[3:0] = raw[3:0];
	w[7:4] = {raw[7], raw[6], raw[4], raw[5]};
	w[8] = swap ? raw[9] : raw[10];
	w[9] = swap ? raw[10] : raw[9];
	w[10] = raw[11] | (raw[10] & raw[5]);
	w[11] = raw[8];
	return w;
endfunction

// Merged control set from the raw words and JOYCFG bits 3..0
function automatic bw_pkg::ctrl_t ref_ctrl(input logic [15:0] u1, input logic [15:0] u2,
	input bw_pkg::db_pair_t d9, input bw_pkg::db_pair_t d15, input logic [3:0] cfg);
	logic [11:0] p1;
	logic [11:0] p2;
	bw_pkg::db_pair_t ad;
	bw_pkg::ctrl_t c;
	ad = (cfg[1:0] == 2'd1) ? d15 : d9;
	p1 = u1[11:0];
	p2 = u2[11:0];
	if (cfg[1:0] != 2'd0) begin
		p1 = ref_player(ad.p1, 1'b0);
		p2 = cfg[2] ? ref_player(ad.p2, 1'b1) : u1[11:0];
	end
	{c.up, c.down, c.left, c.right} = p1[3:0];
	// Player 2 stick doubles as fire
	{c.fire_up, c.fire_down, c.fire_left, c.fire_right} = p1[7:4] | p2[3:0];
	c.start1 = p1[8] | p2[8];
	c.start2 = p1[9] | p2[9];
	c.coin = p1[10] | p2[10];
	c.pause = p1[11] | p2[11];
	return c;
endfunction

// Port image for a raw game byte
function automatic bw_pkg::ports_t ref_ports(input logic [7:0] g, input bw_pkg::ctrl_t c,
	input logic [7:0] d0, input logic [7:0] d1, input logic [7:0] d2);
	bw_pkg::ports_t p;
	p = {8'hff, d0, d1, 8'hff, 8'hff};
	if (g <= 8'd2) begin
		p.in0 = ~{2'b01, d2[0], d2[1], 2'b00, c.coin, 1'b0};
	end
	if (g == 8'd0) begin
		p.in3 = ~{4'h0, c.up, c.down, c.left, c.right};
		p.in4 = ~{1'b0, c.start2, c.start1, 1'b0,
			c.fire_up, c.fire_down, c.fire_left, c.fire_right};
	end else if (g == 8'd1) begin
		p.in3 = ~{3'b000, c.fire_left, c.left, c.right, c.fire_right, c.fire_down};
		p.in4 = ~{1'b0, c.start2, c.start1, 5'b00000};
	end else if (g == 8'd2) begin
		p.in1 = 8'hff;
		p.in2 = 8'hff;
		p.in3 = {1'b0, c.start2, c.start1, c.fire_left, c.fire_down, c.fire_right,
			c.right, c.left};
	end
	return p;
endfunction

// Toggle flips on a button rising edge
function automatic logic ref_toggle(input logic t, input logic prev, input logic btn);
	return t ^ (btn & ~prev);
endfunction

// Next pause_cpu from the updated toggle and the hold sources
function automatic logic ref_pause(input logic t, input logic req, input logic osd,
	input logic on_osd);
	return t | req | (osd & on_osd);
endfunction

`endif

// ==== tb/bw_tb.sv ====
/* Testbench for the cabinet input subsystem. Inputs change on the falling edge.
   The register mirror assumes each write is acked, and outputs are checked every cycle. */
`timescale 1ns/1ps

module bw_tb;

	localparam int PERIOD = 100;
	localparam int ACK_LIMIT = 8;
	// Rough cycles per bus access
	localparam int BUS_CYC = 3;
	localparam int TEST_CYCLES = 16 + (20 * BUS_CYC + 4) + (36 * BUS_CYC + 4)
		+ 5 * (4 * BUS_CYC + 100) + 12 * (2 * BUS_CYC + 40) + 80;
	localparam int WATCHDOG_NS = TEST_CYCLES * 4 * PERIOD;

	logic clk_12;
	logic rst_n;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [3:0] wb_adr;
	logic [7:0] wb_dat_w;
	logic [7:0] wb_dat_r;
	logic wb_ack;
	logic [15:0] usb_p1;
	logic [15:0] usb_p2;
	bw_pkg::db_pair_t db9;
	bw_pkg::db_pair_t db15;
	logic pause_request;
	logic osd_open;
	bw_pkg::ports_t ports;
	logic pause_cpu;

	// Mirror of the registers and model state
	logic [7:0] game_m;
	logic [3:0] jcfg_m;
	logic [7:0] dip_m [8];
	bw_pkg::ctrl_t ctrl_m;
	bw_pkg::ports_t exp_ports;
	logic exp_pause;
	logic toggle_m;
	logic btn_m;
	logic check_on;
	int checks;
	int errors;

	`include "bw_ref.svh"

	bw_input_top dut_i (.*);

	initial begin
		clk_12 = 1'b0;
		forever #(PERIOD / 2) clk_12 = ~clk_12;
	end

	// ====================
	// Model and compare
	// ====================

	always @(posedge clk_12) begin
		if (!rst_n) begin
			exp_ports = '1;
			exp_pause = 1'b0;
			toggle_m = 1'b0;
			btn_m = 1'b0;
		end else begin
			ctrl_m = ref_ctrl(usb_p1, usb_p2, db9, db15, jcfg_m);
			exp_ports = ref_ports(game_m, ctrl_m, dip_m[0], dip_m[1], dip_m[2]);
			toggle_m = ref_toggle(toggle_m, btn_m, ctrl_m.pause);
			exp_pause = ref_pause(toggle_m, pause_request, osd_open, jcfg_m[3]);
			btn_m = ctrl_m.pause;
		end
	end

	task automatic check_value(input string name, input logic [39:0] got,
		input logic [39:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("CHECK FAILED %s: expected %h, got %h", name, exp, got);
			errors++;
		end
	endtask

	// Outputs are stable at the falling edge
	always @(negedge clk_12) begin
		if (check_on) begin
			check_value("ports", ports, exp_ports);
			check_value("pause_cpu", pause_cpu, exp_pause);
		end
	end

	// ====================
	// Wishbone access
	// ====================

	task automatic bus_cycle(input logic we, input logic [3:0] adr, input logic [7:0] wdat,
		output logic [7:0] rdat);
		int n;
		logic ok;
		@(negedge clk_12);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = wdat;
		n = 0;
		ok = 1'b0;
		while (!ok && n < ACK_LIMIT) begin
			@(negedge clk_12);
			n++;
			ok = wb_ack;
		end
		rdat = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		if (!ok) begin
			$display("Wishbone ack never came for address %h", adr);
			errors++;
		end else if (we) begin
			// Write landed on the edge that raised ack
			if (adr == 4'd0) begin
				game_m = wdat;
			end else if (adr == 4'd1) begin
				jcfg_m = wdat[3:0];
			end else if (adr[3]) begin
				dip_m[adr[2:0]] = wdat;
			end
		end
	endtask

	task automatic write_reg(input logic [3:0] adr, input logic [7:0] wdat);
		logic [7:0] unused;
		bus_cycle(1'b1, adr, wdat, unused);
	endtask

	// Expected readback from the mirror with zero when unmapped
	function automatic logic [7:0] expected_read(input logic [3:0] adr);
		if (adr == 4'd0) begin
			return game_m;
		end else if (adr == 4'd1) begin
			return {4'h0, jcfg_m};
		end else if (adr[3]) begin
			return dip_m[adr[2:0]];
		end
		return 8'h00;
	endfunction

	task automatic read_expect(input logic [3:0] adr);
		logic [7:0] rd;
		bus_cycle(1'b0, adr, 8'h00, rd);
		check_value("wb_dat_r", rd, expected_read(adr));
	endtask

	task automatic report_test(input string name, input int c0, input int e0);
		$display("test %s: %0d checks, %0d errors", name, checks - c0, errors - e0);
	endtask

	// ====================
	// Tests
	// ====================

	task automatic test_reset();
		int c0;
		int e0;
		int n;
		c0 = checks;
		e0 = errors;
		// Reset values stand until the first edge with rst_n high
		check_value("ports", ports, 40'hff_ffff_ffff);
		check_value("pause_cpu", pause_cpu, 0);
		@(posedge clk_12);
		check_on = 1'b1;
		for (int a = 0; a < 16; a++) begin
			read_expect(a[3:0]);
		end
		// Ack must drop even while stb stays high
		@(negedge clk_12);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_adr = 4'd0;
		n = 0;
		while (!wb_ack && n < ACK_LIMIT) begin
			@(negedge clk_12);
			n++;
		end
		if (!wb_ack) begin
			$display("Wishbone ack never came while stb was held");
			errors++;
		end
		@(negedge clk_12);
		check_value("wb_ack", wb_ack, 0);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		report_test("reset state", c0, e0);
	endtask

	task automatic test_regs();
		int c0;
		int e0;
		c0 = checks;
		e0 = errors;
		write_reg(4'd0, 8'($urandom));
		write_reg(4'd1, 8'($urandom));
		for (int a = 2; a < 16; a++) begin
			write_reg(a[3:0], 8'($urandom));
		end
		for (int a = 0; a < 16; a++) begin
			read_expect(a[3:0]);
		end
		write_reg(4'd0, 8'd0);
		write_reg(4'd1, 8'd0);
		@(negedge clk_12);
		check_value("ports.in1", ports.in1, dip_m[0]);
		check_value("ports.in2", ports.in2, dip_m[1]);
		report_test("register readback", c0, e0);
	endtask

	task automatic test_usb();
		logic [7:0] games [5] = '{8'd0, 8'd1, 8'd2, 8'd3, 8'd200};
		int c0;
		int e0;
		c0 = checks;
		e0 = errors;
		write_reg(4'd1, 8'd0);
		foreach (games[i]) begin
			write_reg(4'd0, games[i]);
			for (int d = 0; d < 3; d++) begin
				write_reg(4'd8 + d[3:0], 8'($urandom));
			end
			repeat (100) begin
				@(negedge clk_12);
				usb_p1 = 16'($urandom);
				usb_p2 = 16'($urandom);
			end
		end
		report_test("usb per game", c0, e0);
	endtask

	task automatic test_retro();
		int c0;
		int e0;
		c0 = checks;
		e0 = errors;
		// Black Widow then Lunar Battle
		for (int g = 0; g <= 2; g += 2) begin
			write_reg(4'd0, g[7:0]);
			for (int s = 1; s < 4; s++) begin
				for (int tp = 0; tp < 2; tp++) begin
					write_reg(4'd1, {5'd0, tp[0], s[1:0]});
					repeat (40) begin
						@(negedge clk_12);
						db9 = $urandom;
						db15 = $urandom;
						usb_p1 = 16'($urandom);
						usb_p2 = 16'($urandom);
					end
				end
			end
		end
		report_test("retro sources", c0, e0);
	endtask

	task automatic test_pause();
		int c0;
		int e0;
		int presses;
		logic level;
		c0 = checks;
		e0 = errors;
		write_reg(4'd1, 8'd0);
		@(negedge clk_12);
		usb_p1 = '0;
		usb_p2 = '0;
		db9 = '0;
		db15 = '0;
		repeat (2) @(negedge clk_12);
		// One extra press when the toggle starts set, so it ends released
		level = toggle_m;
		presses = level ? 5 : 4;
		repeat (presses) begin
			level = !level;
			usb_p1[11] = 1'b1;
			@(negedge clk_12);
			check_value("pause_cpu", pause_cpu, level);
			@(negedge clk_12);
			usb_p1[11] = 1'b0;
			repeat (2) @(negedge clk_12);
		end
		pause_request = 1'b1;
		@(negedge clk_12);
		check_value("pause_cpu", pause_cpu, 1);
		pause_request = 1'b0;
		osd_open = 1'b1;
		repeat (2) @(negedge clk_12);
		// Toggle released and OSD pause still disabled
		check_value("pause_cpu", pause_cpu, 0);
		write_reg(4'd1, 8'h08);
		@(negedge clk_12);
		check_value("pause_cpu", pause_cpu, 1);
		osd_open = 1'b0;
		write_reg(4'd1, 8'd0);
		report_test("pause", c0, e0);
	endtask

	// ====================
	// Main sequence
	// ====================

	initial begin
		rst_n = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		usb_p1 = '0;
		usb_p2 = '0;
		db9 = '0;
		db15 = '0;
		pause_request = 1'b0;
		osd_open = 1'b0;
		game_m = '0;
		jcfg_m = '0;
		foreach (dip_m[i]) begin
			dip_m[i] = '0;
		end
		check_on = 1'b0;
		checks = 0;
		errors = 0;
		void'($urandom(32'hfcf));
		repeat (16) @(posedge clk_12);
		@(negedge clk_12);
		rst_n = 1'b1;
		test_reset();
		test_regs();
		test_usb();
		test_retro();
		test_pause();
		check_on = 1'b0;
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before the tests finished");
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== filelist.f ====
+incdir+tb
rtl/bw_pkg.sv
rtl/cfg_regs.sv
rtl/joy_merge.sv
rtl/input_port_mux.sv
rtl/pause_ctrl.sv
rtl/bw_input_top.sv
tb/bw_tb.sv

// ==== Bender.yml ====
package:
  name: bw_input

sources:
  - files:
      - rtl/bw_pkg.sv
      - rtl/cfg_regs.sv
      - rtl/joy_merge.sv
      - rtl/input_port_mux.sv
      - rtl/pause_ctrl.sv
      - rtl/bw_input_top.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/bw_tb.sv
